// File: bench/mdu_cases.txt
# op src1 src2 expected gap, all hex; op is the mdu_op_e code
# gap is the number of idle cycles before the issue
0 0000000000000007 0000000000000006 000000000000002a 0
0 8000000000000000 ffffffffffffffff 8000000000000000 0
1 8000000000000000 ffffffffffffffff 0000000000000000 0
1 8000000000000000 8000000000000000 4000000000000000 0
3 ffffffffffffffff ffffffffffffffff fffffffffffffffe 0
2 ffffffffffffffff ffffffffffffffff ffffffffffffffff 0
2 0000000000000002 ffffffffffffffff 0000000000000001 0
0 0000000100000001 0000000100000001 0000000200000001 0
4 1234567880000000 0000000000000001 ffffffff80000000 0
4 00000000ffffffff 0000000000000003 fffffffffffffffd 0
0 123456789abcdef0 0000000000000000 0000000000000000 0
0 123456789abcdef0 0000000000000001 123456789abcdef0 0
0 123456789abcdef0 ffffffffffffffff edcba98765432110 0
1 123456789abcdef0 ffffffffffffffff ffffffffffffffff 0
3 deadbeef00000000 0000000000000010 000000000000000d 0
1 deadbeef00000000 0000000000000010 fffffffffffffffd 0
5 0000000000000014 0000000000000006 0000000000000003 3
0 0000000000000003 7fffffffffffffff 7ffffffffffffffd 0
3 0000000000000003 7fffffffffffffff 0000000000000001 0
7 0000000000000014 0000000000000006 0000000000000002 0
5 ffffffffffffffec 0000000000000006 fffffffffffffffd 0
7 ffffffffffffffec 0000000000000006 fffffffffffffffe 0
5 0000000000000014 fffffffffffffffa fffffffffffffffd 0
6 ffffffffffffffec 0000000000000006 2aaaaaaaaaaaaaa7 0
8 ffffffffffffffec 0000000000000006 0000000000000002 0
7 fffffffffffffff9 fffffffffffffffe ffffffffffffffff 0
5 7fffffffffffffff 0000000000000010 07ffffffffffffff 0
2 8000000000000000 0000000000000002 ffffffffffffffff 0
5 0000000000001234 0000000000000000 ffffffffffffffff 0
7 0000000000001234 0000000000000000 0000000000001234 0
6 0000000000001234 0000000000000000 ffffffffffffffff 0
8 8000000000001234 0000000000000000 8000000000001234 0
5 8000000000000000 ffffffffffffffff 8000000000000000 0
7 8000000000000000 ffffffffffffffff 0000000000000000 0
9 0000000080000000 00000000ffffffff ffffffff80000000 0
a 0000000080000000 00000000ffffffff 0000000000000000 0
9 0000000500000007 0000000000000000 ffffffffffffffff 0
a 0000000580000007 0000000000000000 ffffffff80000007 0
9 12345678fffffff9 0000000000000002 fffffffffffffffd 0
a 12345678fffffff9 0000000000000002 ffffffffffffffff 0
9 0000000000000064 fffffffffffffff9 fffffffffffffff2 0
a 0000000000000064 fffffffffffffff9 0000000000000002 0

// File: compile.f
common/mdu_ops_pkg.sv
common/mdu_wb_pkg.sv
booth/booth_mul.sv
design/serial_div.sv
design/wb_arbiter.sv
design/mdu_top.sv
bench/mdu_chk.sv
bench/mdu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mdu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/mdu_tb.sv
`timescale 1ns/10ps

module mdu_tb import mdu_ops_pkg::*; ();

	localparam int TAG_W = 4;
	localparam int NTAGS = 1 << TAG_W;
	localparam string CASES_FILE = "bench/mdu_cases.txt";

	logic             clk;
	logic             rst_n;
	logic             op_valid;
	mdu_op_e          op;
	logic [XLEN-1:0]  src1;
	logic [XLEN-1:0]  src2;
	logic [TAG_W-1:0] op_tag;
	logic             op_ready;
	logic             wb_valid;
	logic [XLEN-1:0]  wb_data;
	logic [TAG_W-1:0] wb_tag;

	mdu_op_e          case_op[$];
	logic [XLEN-1:0]  case_a[$];
	logic [XLEN-1:0]  case_b[$];
	logic [XLEN-1:0]  case_exp[$];
	int               case_gap[$];
	logic [XLEN-1:0]  exp_by_tag [NTAGS];
	int               issued_cnt [NTAGS] = '{default: 0};
	int               returned_cnt [NTAGS] = '{default: 0};
	logic [TAG_W-1:0] next_tag = '0;
	int               n_cases = 0;
	int               n_done = 0;
	int               errors = 0;
	int               cycles = 0;
	int               cycle_limit = 0;

	mdu_top #(
		.TAG_W(TAG_W)
	) mdu_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.op_valid (op_valid),
		.op       (op),
		.src1     (src1),
		.src2     (src2),
		.op_tag   (op_tag),
		.op_ready (op_ready),
		.wb_valid (wb_valid),
		.wb_data  (wb_data),
		.wb_tag   (wb_tag)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
			input string what);
		if (got !== exp) begin
			errors = errors + 1;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("tests failed");
			$fatal(1, "result mismatch");
		end
	endtask

	task automatic load_cases();
		int              fd;
		int              n;
		int              gap;
		string           line;
		logic [3:0]      op_raw;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] e;
		fd = $fopen(CASES_FILE, "r");
		if (fd == 0) begin
			$display("error: cannot open %s", CASES_FILE);
			$display("tests failed");
			$fatal(1, "no cases file");
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.getc(0) != "#") begin	// comment lines skipped
				n = $sscanf(line, "%h %h %h %h %h", op_raw, a, b, e, gap);
				if (n == 5) begin
					case_op.push_back(mdu_op_e'(op_raw));
					case_a.push_back(a);
					case_b.push_back(b);
					case_exp.push_back(e);
					case_gap.push_back(gap);
				end
			end
		end
		$fclose(fd);
	endtask

	// called right after a falling edge
	task automatic issue_case(input int i);
		logic [TAG_W-1:0] tag;
		tag = next_tag;
		repeat (case_gap[i]) @(negedge clk);
		if (issued_cnt[tag] != returned_cnt[tag]) begin
			$display("error: tag %0d is reused while its result is still outstanding", tag);
			$display("tests failed");
			$fatal(1, "tag overrun");
		end
		op_valid = 1'b1;
		op       = case_op[i];
		src1     = case_a[i];
		src2     = case_b[i];
		op_tag   = tag;
		#1;	// op_ready follows op combinationally
		while (!op_ready) begin
			@(negedge clk);
			#1;
		end
		exp_by_tag[tag] = case_exp[i];
		issued_cnt[tag] = issued_cnt[tag] + 1;
		next_tag = next_tag + TAG_W'(1);
		@(negedge clk);	// accepted on the rising edge in between
		op_valid = 1'b0;
	endtask

	// writeback monitor, bus is stable at the falling edge
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (issued_cnt[wb_tag] == returned_cnt[wb_tag]) begin
				$display("error: writeback for tag %0d with no operation in flight", wb_tag);
				$display("tests failed");
				$fatal(1, "unexpected writeback");
			end
			check_value(wb_data, exp_by_tag[wb_tag], $sformatf("result of tag %0d", wb_tag));
			returned_cnt[wb_tag] = returned_cnt[wb_tag] + 1;
			n_done = n_done + 1;
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			cycles = cycles + 1;
			if (cycle_limit > 0 && cycles > cycle_limit) begin
				$display("error: timeout after %0d cycles, %0d of %0d results returned",
					cycles, n_done, n_cases);
				$display("tests failed");
				$fatal(1, "timeout");
			end
		end
	end

	initial begin
		rst_n    = 1'b0;
		op_valid = 1'b0;
		op       = OP_MUL;
		src1     = '0;
		src2     = '0;
		op_tag   = '0;
		load_cases();
		n_cases = case_op.size();
		if (n_cases == 0) begin
			$display("error: no cases found in %s", CASES_FILE);
			$display("tests failed");
			$fatal(1, "empty cases file");
		end
		cycle_limit = 80 * n_cases + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_cases; i++)
			issue_case(i);
		while (n_done < n_cases)
			@(negedge clk);
		repeat (4) @(negedge clk);	// room for a stray writeback
		if (errors == 0 && n_done == n_cases)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: bench/mdu_chk.sv
`timescale 1ns/10ps

module mdu_chk #(
	parameter int TAG_W = 4
) (
	input logic             clk,
	input logic             rst_n,
	input logic             op_ready,
	input logic             mul_valid,
	input logic             mul_grant,
	input logic             div_valid,
	input logic             div_grant,
	input logic             wb_valid,
	input logic [TAG_W-1:0] wb_tag
);

	// both units idle right after reset
	ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> op_ready)
		else $error("op_ready low in the first cycle after reset");

	// a held result loses at most one tie before it gets the bus
	mul_served: assert property (@(posedge clk) disable iff (!rst_n)
		mul_valid |=> (!mul_valid || mul_grant))
		else $error("multiplier result waited more than one cycle for a grant");

	div_served: assert property (@(posedge clk) disable iff (!rst_n)
		div_valid |=> (!div_valid || div_grant))
		else $error("divider result waited more than one cycle for a grant");

	// back to back writebacks must carry different tags
	single_wb: assert property (@(posedge clk) disable iff (!rst_n)
		(wb_valid && $past(wb_valid)) |-> (wb_tag != $past(wb_tag)))
		else $error("writeback held two cycles for tag %0d", wb_tag);

endmodule

bind mdu_top mdu_chk #(.TAG_W(TAG_W)) mdu_chk_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.op_ready  (op_ready),
	.mul_valid (mul_res_valid),
	.mul_grant (mul_grant),
	.div_valid (div_res_valid),
	.div_grant (div_grant),
	.wb_valid  (wb_valid),
	.wb_tag    (wb_tag)
);

// File: design/mdu_top.sv
`timescale 1ns/10ps

module mdu_top import mdu_ops_pkg::*; #(
	parameter int TAG_W = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             op_valid,
	input  mdu_op_e          op,
	input  logic [XLEN-1:0]  src1,
	input  logic [XLEN-1:0]  src2,
	input  logic [TAG_W-1:0] op_tag,
	output logic             op_ready,
	output logic             wb_valid,
	output logic [XLEN-1:0]  wb_data,
	output logic [TAG_W-1:0] wb_tag
);

	logic             mul_ready;
	logic             mul_res_valid;
	logic [XLEN-1:0]  mul_res_data;
	logic [TAG_W-1:0] mul_res_tag;
	logic             mul_grant;
	logic             div_ready;
	logic             div_res_valid;
	logic [XLEN-1:0]  div_res_data;
	logic [TAG_W-1:0] div_res_tag;
	logic             div_grant;

	assign op_ready = mul_ready | div_ready;	// each unit claims its own class

	booth_mul #(
		.TAG_W(TAG_W)
	) booth_mul_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op        (op),
		.src1      (src1),
		.src2      (src2),
		.op_tag    (op_tag),
		.grant     (mul_grant),
		.ready     (mul_ready),
		.res_valid (mul_res_valid),
		.res_data  (mul_res_data),
		.res_tag   (mul_res_tag)
	);

	serial_div #(
		.TAG_W(TAG_W)
	) serial_div_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.op_valid  (op_valid),
		.op        (op),
		.src1      (src1),
		.src2      (src2),
		.op_tag    (op_tag),
		.grant     (div_grant),
		.ready     (div_ready),
		.res_valid (div_res_valid),
		.res_data  (div_res_data),
		.res_tag   (div_res_tag)
	);

	wb_arbiter #(
		.TAG_W(TAG_W)
	) wb_arbiter_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.mul_valid (mul_res_valid),
		.mul_data  (mul_res_data),
		.mul_tag   (mul_res_tag),
		.div_valid (div_res_valid),
		.div_data  (div_res_data),
		.div_tag   (div_res_tag),
		.mul_grant (mul_grant),
		.div_grant (div_grant),
		.wb_valid  (wb_valid),
		.wb_data   (wb_data),
		.wb_tag    (wb_tag)
	);

endmodule

// File: design/wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter import mdu_ops_pkg::*, mdu_wb_pkg::*; #(
	parameter int TAG_W = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             mul_valid,
	input  logic [XLEN-1:0]  mul_data,
	input  logic [TAG_W-1:0] mul_tag,
	input  logic             div_valid,
	input  logic [XLEN-1:0]  div_data,
	input  logic [TAG_W-1:0] div_tag,
	output logic             mul_grant,
	output logic             div_grant,
	output logic             wb_valid,
	output logic [XLEN-1:0]  wb_data,
	output logic [TAG_W-1:0] wb_tag
);

	wb_src_e last_src;
	logic    mul_gnt_q;
	logic    div_gnt_q;
	logic    mul_req;
	logic    div_req;

	// a unit granted last cycle is already dropping its valid
	assign mul_req = mul_valid && !mul_gnt_q;
	assign div_req = div_valid && !div_gnt_q;

	assign mul_grant = mul_req && (!div_req || last_src == SRC_DIV);
	assign div_grant = div_req && (!mul_req || last_src == SRC_MUL);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_src  <= WB_LAST_RST;
			mul_gnt_q <= 1'b0;
			div_gnt_q <= 1'b0;
			wb_valid  <= 1'b0;
		end else begin
			mul_gnt_q <= mul_grant;
			div_gnt_q <= div_grant;
			wb_valid  <= mul_grant || div_grant;
			if (mul_grant)
				last_src <= SRC_MUL;
			else if (div_grant)
				last_src <= SRC_DIV;
		end
	end

	always_ff @(posedge clk) begin
		if (mul_grant) begin
			wb_data <= mul_data;
			wb_tag  <= mul_tag;
		end else if (div_grant) begin
			wb_data <= div_data;
			wb_tag  <= div_tag;
		end
	end

endmodule

// File: design/serial_div.sv
`timescale 1ns/10ps

module serial_div import mdu_ops_pkg::*; #(
	parameter int TAG_W = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             op_valid,
	input  mdu_op_e          op,
	input  logic [XLEN-1:0]  src1,
	input  logic [XLEN-1:0]  src2,
	input  logic [TAG_W-1:0] op_tag,
	input  logic             grant,
	output logic             ready,
	output logic             res_valid,
	output logic [XLEN-1:0]  res_data,
	output logic [TAG_W-1:0] res_tag
);

	localparam int CNT_W = $clog2(XLEN);
	localparam logic [XLEN-1:0] X_MIN = {1'b1, {(XLEN-1){1'b0}}};
	localparam logic [XLEN-1:0] W_MIN = {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}};

	typedef enum logic [2:0] {
		S_IDLE,
		S_PREP,
		S_RUN,
		S_FIX,
		S_HOLD
	} state_e;

	state_e           state;
	mdu_op_e          op_q;
	logic [XLEN-1:0]  src_a;
	logic [XLEN-1:0]  src_b;
	logic [XLEN-1:0]  a_ext;
	logic [XLEN-1:0]  b_ext;
	logic [XLEN-1:0]  dvsr;
	logic [XLEN-1:0]  quo;
	logic [XLEN-1:0]  rem;
	logic [XLEN-1:0]  q_fix;
	logic [XLEN-1:0]  r_fix;
	logic [XLEN-1:0]  res_sel;
	logic [CNT_W-1:0] cnt;
	logic             sgn;
	logic             want_q;
	logic             a_neg;
	logic             b_neg;
	logic             div_zero;
	logic             ovf;
	logic [XLEN:0]    rem_sh;
	logic [XLEN+1:0]  diff;

	assign ready     = (state == S_IDLE) && !is_mul_op(op);
	assign res_valid = (state == S_HOLD);

	always_comb begin
		sgn    = (op_q == OP_DIV) || (op_q == OP_REM) || is_w_op(op_q);
		want_q = (op_q == OP_DIV) || (op_q == OP_DIVU) || (op_q == OP_DIVW);
		if (is_w_op(op_q)) begin
			a_ext = {{(XLEN-WLEN){src_a[WLEN-1]}}, src_a[WLEN-1:0]};
			b_ext = {{(XLEN-WLEN){src_b[WLEN-1]}}, src_b[WLEN-1:0]};
		end else begin
			a_ext = src_a;
			b_ext = src_b;
		end
		a_neg    = sgn & a_ext[XLEN-1];
		b_neg    = sgn & b_ext[XLEN-1];
		div_zero = (b_ext == '0);
		ovf      = sgn && (&b_ext) && (a_ext == (is_w_op(op_q) ? W_MIN : X_MIN));
	end

	// restoring step
	always_comb begin
		rem_sh = {rem, quo[XLEN-1]};
		diff   = {1'b0, rem_sh} - {2'b00, dvsr};
	end

	always_comb begin
		q_fix = (a_neg ^ b_neg) ? -quo : quo;
		r_fix = a_neg ? -rem : rem;	// remainder follows the dividend
		if (div_zero) begin
			q_fix = '1;
			r_fix = a_ext;
		end else if (ovf) begin
			q_fix = a_ext;
			r_fix = '0;
		end
		res_sel = want_q ? q_fix : r_fix;
		if (is_w_op(op_q))
			res_sel = {{(XLEN-WLEN){res_sel[WLEN-1]}}, res_sel[WLEN-1:0]};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (op_valid && ready) state <= S_PREP;
				S_PREP: state <= S_RUN;
				S_RUN:  if (cnt == '0) state <= S_FIX;
				S_FIX:  state <= S_HOLD;
				S_HOLD: if (grant) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			S_IDLE: begin
				if (op_valid && ready) begin
					op_q    <= op;
					src_a   <= src1;
					src_b   <= src2;
					res_tag <= op_tag;
				end
			end
			S_PREP: begin
				quo  <= a_neg ? -a_ext : a_ext;	// magnitudes
				dvsr <= b_neg ? -b_ext : b_ext;
				rem  <= '0;
				cnt  <= CNT_W'(XLEN - 1);
			end
			S_RUN: begin
				cnt <= cnt - CNT_W'(1);
				if (diff[XLEN+1]) begin
					rem <= rem_sh[XLEN-1:0];
					quo <= {quo[XLEN-2:0], 1'b0};
				end else begin
					rem <= diff[XLEN-1:0];
					quo <= {quo[XLEN-2:0], 1'b1};
				end
			end
			S_FIX: res_data <= res_sel;
			default: ;
		endcase
	end

endmodule

// File: booth/booth_mul.sv
`timescale 1ns/10ps

module booth_mul import mdu_ops_pkg::*; #(
	parameter int TAG_W = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             op_valid,
	input  mdu_op_e          op,
	input  logic [XLEN-1:0]  src1,
	input  logic [XLEN-1:0]  src2,
	input  logic [TAG_W-1:0] op_tag,
	input  logic             grant,
	output logic             ready,
	output logic             res_valid,
	output logic [XLEN-1:0]  res_data,
	output logic [TAG_W-1:0] res_tag
);

	localparam int OPW = XLEN + 2;		// operands with two extension bits
	localparam int PW  = 2 * OPW - 2;	// partial product width

	typedef enum logic [1:0] {
		S_IDLE,
		S_RUN,
		S_HOLD
	} state_e;

	state_e          state;
	mdu_op_e         op_q;
	logic            s1_signed;
	logic            s2_signed;
	logic [OPW-1:0]  x_ext;
	logic [OPW-1:0]  y_ext;
	logic [PW-1:0]   mcand;
	logic [PW-1:0]   acc;
	logic [PW-1:0]   addend;
	logic [PW-1:0]   acc_nxt;
	logic [OPW:0]    mplr;		// multiplier with the implicit zero below bit 0
	logic [OPW:0]    mplr_nxt;
	logic            done;
	logic [XLEN-1:0] sel;

	assign ready     = (state == S_IDLE) && is_mul_op(op);
	assign res_valid = (state == S_HOLD);

	always_comb begin
		s1_signed = (op != OP_MULHU);
		s2_signed = (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULW);
		x_ext = {{2{s1_signed & src1[XLEN-1]}}, src1};
		// low word of the product only needs the low half of the multiplier
		if (is_w_op(op))
			y_ext = {{(OPW-WLEN){src2[WLEN-1]}}, src2[WLEN-1:0]};
		else
			y_ext = {{2{s2_signed & src2[XLEN-1]}}, src2};
	end

	// one booth digit per cycle
	always_comb begin
		case (mplr[2:0])
			3'b001, 3'b010: addend = mcand;
			3'b011:         addend = mcand << 1;
			3'b100:         addend = -(mcand << 1);
			3'b101, 3'b110: addend = -mcand;
			default:        addend = '0;
		endcase
		acc_nxt  = acc + addend;
		mplr_nxt = $signed(mplr) >>> 2;
		done     = (&mplr_nxt) || (mplr_nxt == '0);	// only sign bits left
	end

	always_comb begin
		case (op_q)
			OP_MUL:  sel = acc_nxt[XLEN-1:0];
			OP_MULW: sel = {{(XLEN-WLEN){acc_nxt[WLEN-1]}}, acc_nxt[WLEN-1:0]};
			default: sel = acc_nxt[2*XLEN-1:XLEN];	// mulh forms
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: if (op_valid && ready) state <= S_RUN;
				S_RUN:  if (done) state <= S_HOLD;
				S_HOLD: if (grant) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && op_valid && ready) begin
			op_q    <= op;
			res_tag <= op_tag;
			mcand   <= {{(PW-OPW){x_ext[OPW-1]}}, x_ext};
			mplr    <= {y_ext, 1'b0};
			acc     <= '0;
		end else if (state == S_RUN) begin
			acc   <= acc_nxt;
			mcand <= mcand << 2;
			mplr  <= mplr_nxt;
			if (done)
				res_data <= sel;
		end
	end

endmodule

// File: common/mdu_wb_pkg.sv
package mdu_wb_pkg;

	// requester on the writeback bus, also the last-winner state
	typedef enum logic {
		SRC_MUL = 1'b0,
		SRC_DIV = 1'b1
	} wb_src_e;

	// last winner after reset, so the multiplier wins the first tie
	localparam wb_src_e WB_LAST_RST = SRC_DIV;

endpackage

// File: common/mdu_ops_pkg.sv
package mdu_ops_pkg;

	localparam int XLEN = 64;
	localparam int WLEN = 32;	// width of the W forms

	typedef enum logic [3:0] {
		OP_MUL    = 4'd0,
		OP_MULH   = 4'd1,
		OP_MULHSU = 4'd2,
		OP_MULHU  = 4'd3,
		OP_MULW   = 4'd4,
		OP_DIV    = 4'd5,
		OP_DIVU   = 4'd6,
		OP_REM    = 4'd7,
		OP_REMU   = 4'd8,
		OP_DIVW   = 4'd9,
		OP_REMW   = 4'd10
	} mdu_op_e;

	// routes an issue to the multiplier, everything else goes to the divider
	function automatic logic is_mul_op(mdu_op_e op);
		return (op == OP_MUL) || (op == OP_MULH) || (op == OP_MULHSU) ||
			(op == OP_MULHU) || (op == OP_MULW);
	endfunction

	// 32-bit forms, result sign extended from bit 31
	function automatic logic is_w_op(mdu_op_e op);
		return (op == OP_MULW) || (op == OP_DIVW) || (op == OP_REMW);
	endfunction

endpackage
